// ==== src/rv_pkg.sv ====
package rv_pkg;

  // ==================================================
  // widths and basic types
  // ==================================================
  localparam int XLEN = 32;

  typedef logic [XLEN-1:0] word_t;
  typedef logic [4:0]      reg_addr_t;
  typedef logic [6:0]      opcode_t;
  typedef logic [3:0]      alu_op_t;

  // major opcodes of the supported instructions
  localparam opcode_t OPC_OP     = 7'b0110011;
  localparam opcode_t OPC_OP_IMM = 7'b0010011;
  localparam opcode_t OPC_LUI    = 7'b0110111;
  localparam opcode_t OPC_AUIPC  = 7'b0010111;

  // alu operation codes
  localparam alu_op_t ALU_ADD  = 4'd0;
  localparam alu_op_t ALU_SUB  = 4'd1;
  localparam alu_op_t ALU_SLL  = 4'd2;
  localparam alu_op_t ALU_SLT  = 4'd3;
  localparam alu_op_t ALU_SLTU = 4'd4;
  localparam alu_op_t ALU_XOR  = 4'd5;
  localparam alu_op_t ALU_SRL  = 4'd6;
  localparam alu_op_t ALU_SRA  = 4'd7;
  localparam alu_op_t ALU_OR   = 4'd8;
  localparam alu_op_t ALU_AND  = 4'd9;

  // addi x0, x0, 0
  localparam word_t NOP_INST = 32'h0000_0013;
  localparam word_t RESET_PC = 32'h0000_0000;

  // ==================================================
  // pipeline registers
  // ==================================================
  typedef struct packed {
    word_t pc;
    word_t inst;
  } if_id_t;

  typedef struct packed {
    word_t     pc;
    reg_addr_t rs1;
    reg_addr_t rs2;
    reg_addr_t rd;
    word_t     rs1_val;
    word_t     rs2_val;
    word_t     imm;
    alu_op_t   alu_op;
    logic      alu_src;
    logic      auipc;
    logic      lui;
    logic      reg_write;
  } id_ex_t;

  typedef struct packed {
    reg_addr_t rd;
    word_t     result;
    logic      reg_write;
  } ex_wb_t;

  // retired register write, seen at the top level
  typedef struct packed {
    logic      we;
    reg_addr_t addr;
    word_t     data;
  } commit_t;

endpackage

// ==== src/fetch_stage.sv ====
`timescale 1ns/1ps

module fetch_stage (
  input  logic           clk,
  input  logic           reset_i,
  input  rv_pkg::word_t  inst_i,
  output rv_pkg::word_t  pc_o,
  output rv_pkg::if_id_t if_id_o
);

  rv_pkg::word_t  pc_q;
  rv_pkg::word_t  pc_plus_4;
  rv_pkg::if_id_t if_id_q;

  // no branches, so the next pc is always sequential
  assign pc_plus_4 = pc_q + 32'd4;

  always_ff @(posedge clk) begin
    if (reset_i) begin
      pc_q    <= rv_pkg::RESET_PC;
      // start decode on a harmless nop
      if_id_q <= '{pc: rv_pkg::RESET_PC, inst: rv_pkg::NOP_INST};
    end else begin
      pc_q    <= pc_plus_4;
      if_id_q <= '{pc: pc_q, inst: inst_i};
    end
  end

  assign pc_o    = pc_q;
  assign if_id_o = if_id_q;

endmodule

// ==== src/reg_file.sv ====
`timescale 1ns/1ps

module reg_file (
  input  logic              clk,
  input  logic              reset_i,
  input  rv_pkg::reg_addr_t raddr1_i,
  input  rv_pkg::reg_addr_t raddr2_i,
  input  logic              we_i,
  input  rv_pkg::reg_addr_t waddr_i,
  input  rv_pkg::word_t     wdata_i,
  output rv_pkg::word_t     rdata1_o,
  output rv_pkg::word_t     rdata2_o
);

  // x0 has no storage
  rv_pkg::word_t regs_q [1:31];

  always_ff @(posedge clk) begin
    if (reset_i) begin
      for (int i = 1; i < 32; i++) begin
        regs_q[i] <= '0;
      end
    end else if (we_i && (waddr_i != '0)) begin
      regs_q[waddr_i] <= wdata_i;
    end
  end

  // same-cycle write is passed through to the reader
  function automatic rv_pkg::word_t read_port(input rv_pkg::reg_addr_t addr);
    rv_pkg::word_t val;
    if (addr == '0) begin
      val = '0;
    end else if (we_i && (addr == waddr_i)) begin
      val = wdata_i;
    end else begin
      val = regs_q[addr];
    end
    return val;
  endfunction

  always_comb begin
    rdata1_o = read_port(raddr1_i);
    rdata2_o = read_port(raddr2_i);
  end

endmodule

// ==== src/decode_stage.sv ====
`timescale 1ns/1ps

module decode_stage (
  input  logic           clk,
  input  logic           reset_i,
  input  rv_pkg::if_id_t if_id_i,
  input  rv_pkg::ex_wb_t wb_i,
  output rv_pkg::id_ex_t id_ex_o
);

  rv_pkg::word_t     inst;
  rv_pkg::opcode_t   opcode;
  rv_pkg::reg_addr_t rs1;
  rv_pkg::reg_addr_t rs2;
  rv_pkg::reg_addr_t rd;
  logic [2:0]        funct3;
  logic              funct7_b5;
  rv_pkg::word_t     rs1_val;
  rv_pkg::word_t     rs2_val;
  rv_pkg::word_t     imm_i;
  rv_pkg::word_t     imm_u;
  rv_pkg::id_ex_t    id_ex_d;
  rv_pkg::id_ex_t    id_ex_q;

  // ==================================================
  // fields and immediates
  // ==================================================
  assign inst      = if_id_i.inst;
  assign opcode    = inst[6:0];
  assign rd        = inst[11:7];
  assign funct3    = inst[14:12];
  assign rs1       = inst[19:15];
  assign rs2       = inst[24:20];
  assign funct7_b5 = inst[30];

  assign imm_i = {{20{inst[31]}}, inst[31:20]};
  assign imm_u = {inst[31:12], 12'b0};

  // register read, with write-back bypass inside
  reg_file rf0 (
    .clk      (clk),
    .reset_i  (reset_i),
    .raddr1_i (rs1),
    .raddr2_i (rs2),
    .we_i     (wb_i.reg_write),
    .waddr_i  (wb_i.rd),
    .wdata_i  (wb_i.result),
    .rdata1_o (rs1_val),
    .rdata2_o (rs2_val)
  );

  // funct3 to alu code, alt picks sub or sra
  function automatic rv_pkg::alu_op_t alu_decode(input logic [2:0] f3, input logic alt);
    rv_pkg::alu_op_t op;
    case (f3)
      3'b000:  op = alt ? rv_pkg::ALU_SUB : rv_pkg::ALU_ADD;
      3'b001:  op = rv_pkg::ALU_SLL;
      3'b010:  op = rv_pkg::ALU_SLT;
      3'b011:  op = rv_pkg::ALU_SLTU;
      3'b100:  op = rv_pkg::ALU_XOR;
      3'b101:  op = alt ? rv_pkg::ALU_SRA : rv_pkg::ALU_SRL;
      3'b110:  op = rv_pkg::ALU_OR;
      default: op = rv_pkg::ALU_AND;
    endcase
    return op;
  endfunction

  // ==================================================
  // control decoder
  // ==================================================
  always_comb begin
    id_ex_d         = '0;
    id_ex_d.pc      = if_id_i.pc;
    id_ex_d.rs1     = rs1;
    id_ex_d.rs2     = rs2;
    id_ex_d.rd      = rd;
    id_ex_d.rs1_val = rs1_val;
    id_ex_d.rs2_val = rs2_val;
    id_ex_d.imm     = imm_i;
    id_ex_d.alu_op  = rv_pkg::ALU_ADD;
    case (opcode)
      rv_pkg::OPC_OP: begin
        id_ex_d.alu_op    = alu_decode(funct3, funct7_b5);
        id_ex_d.reg_write = 1'b1;
      end
      rv_pkg::OPC_OP_IMM: begin
        // only srai uses bit 30, addi has no subtract form
        id_ex_d.alu_op    = alu_decode(funct3, (funct3 == 3'b101) && funct7_b5);
        id_ex_d.alu_src   = 1'b1;
        id_ex_d.reg_write = 1'b1;
      end
      rv_pkg::OPC_LUI: begin
        id_ex_d.imm       = imm_u;
        id_ex_d.lui       = 1'b1;
        id_ex_d.reg_write = 1'b1;
      end
      rv_pkg::OPC_AUIPC: begin
        id_ex_d.imm       = imm_u;
        id_ex_d.auipc     = 1'b1;
        id_ex_d.alu_src   = 1'b1;
        id_ex_d.reg_write = 1'b1;
      end
      default: begin
        // anything else becomes a bubble
        id_ex_d.reg_write = 1'b0;
      end
    endcase
    if (rd == '0) begin
      id_ex_d.reg_write = 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (reset_i) begin
      id_ex_q <= '0;
    end else begin
      id_ex_q <= id_ex_d;
    end
  end

  assign id_ex_o = id_ex_q;

endmodule

// ==== src/execute_stage.sv ====
`timescale 1ns/1ps

module execute_stage (
  input  logic           clk,
  input  logic           reset_i,
  input  rv_pkg::id_ex_t id_ex_i,
  output rv_pkg::ex_wb_t ex_wb_o
);

  rv_pkg::ex_wb_t ex_wb_d;
  rv_pkg::ex_wb_t ex_wb_q;
  rv_pkg::word_t  src1;
  rv_pkg::word_t  src2;
  rv_pkg::word_t  op1;
  rv_pkg::word_t  op2;
  rv_pkg::word_t  alu_res;
  logic [4:0]     shamt;

  // take the write-back result when it targets this source
  function automatic rv_pkg::word_t forward(
    input rv_pkg::reg_addr_t rs,
    input rv_pkg::word_t     rf_val,
    input rv_pkg::ex_wb_t    wb
  );
    rv_pkg::word_t val;
    if (wb.reg_write && (wb.rd == rs) && (rs != '0)) begin
      val = wb.result;
    end else begin
      val = rf_val;
    end
    return val;
  endfunction

  // ==================================================
  // operand selection
  // ==================================================
  assign src1 = forward(id_ex_i.rs1, id_ex_i.rs1_val, ex_wb_q);
  assign src2 = forward(id_ex_i.rs2, id_ex_i.rs2_val, ex_wb_q);

  // auipc adds the immediate to its own pc
  assign op1   = id_ex_i.auipc ? id_ex_i.pc : src1;
  assign op2   = id_ex_i.alu_src ? id_ex_i.imm : src2;
  assign shamt = op2[4:0];

  // ==================================================
  // alu
  // ==================================================
  always_comb begin
    case (id_ex_i.alu_op)
      rv_pkg::ALU_ADD:  alu_res = op1 + op2;
      rv_pkg::ALU_SUB:  alu_res = op1 - op2;
      rv_pkg::ALU_SLL:  alu_res = op1 << shamt;
      rv_pkg::ALU_SLT:  alu_res = {31'b0, $signed(op1) < $signed(op2)};
      rv_pkg::ALU_SLTU: alu_res = {31'b0, op1 < op2};
      rv_pkg::ALU_XOR:  alu_res = op1 ^ op2;
      rv_pkg::ALU_SRL:  alu_res = op1 >> shamt;
      rv_pkg::ALU_SRA:  alu_res = $unsigned($signed(op1) >>> shamt);
      rv_pkg::ALU_OR:   alu_res = op1 | op2;
      default:          alu_res = op1 & op2;
    endcase
  end

  // lui bypasses the alu
  assign ex_wb_d = '{
    rd:        id_ex_i.rd,
    result:    id_ex_i.lui ? id_ex_i.imm : alu_res,
    reg_write: id_ex_i.reg_write
  };

  always_ff @(posedge clk) begin
    if (reset_i) begin
      ex_wb_q <= '0;
    end else begin
      ex_wb_q <= ex_wb_d;
    end
  end

  assign ex_wb_o = ex_wb_q;

endmodule

// ==== src/rv_pipeline_top.sv ====
`timescale 1ns/1ps

module rv_pipeline_top (
  input  logic            clk,
  input  logic            reset_i,
  input  rv_pkg::word_t   inst_i,
  output rv_pkg::word_t   pc_o,
  output rv_pkg::commit_t commit_o
);

  rv_pkg::if_id_t if_id;
  rv_pkg::id_ex_t id_ex;
  rv_pkg::ex_wb_t ex_wb;

  // ==================================================
  // stages
  // ==================================================
  fetch_stage fetch0 (
    .clk     (clk),
    .reset_i (reset_i),
    .inst_i  (inst_i),
    .pc_o    (pc_o),
    .if_id_o (if_id)
  );

  // write-back goes straight from ex/wb into the register file
  decode_stage decode0 (
    .clk     (clk),
    .reset_i (reset_i),
    .if_id_i (if_id),
    .wb_i    (ex_wb),
    .id_ex_o (id_ex)
  );

  execute_stage execute0 (
    .clk     (clk),
    .reset_i (reset_i),
    .id_ex_i (id_ex),
    .ex_wb_o (ex_wb)
  );

  // commit port mirrors the write-back register
  assign commit_o = '{
    we:   ex_wb.reg_write,
    addr: ex_wb.rd,
    data: ex_wb.result
  };

endmodule

// ==== tb/rv_pipeline_checker.sv ====
`timescale 1ns/1ps

module rv_pipeline_checker (
  input logic            clk,
  input logic            reset_i,
  input rv_pkg::word_t   pc_i,
  input rv_pkg::commit_t commit_i
);

  // ==================================================
  // reset state
  // ==================================================
  held_in_reset_a: assert property (@(posedge clk)
    reset_i |=> (pc_i == rv_pkg::RESET_PC) && !commit_i.we)
    else $error("pc or commit enable wrong while reset is held");

  // pipeline still holds bubbles for three cycles
  quiet_after_reset_a: assert property (@(posedge clk)
    !reset_i && ($past(reset_i, 1) || $past(reset_i, 2) || $past(reset_i, 3))
      |-> !commit_i.we)
    else $error("commit seen before the first instruction could retire");

  // ==================================================
  // steady state
  // ==================================================
  pc_step_a: assert property (@(posedge clk)
    !reset_i && !$past(reset_i) |-> (pc_i == $past(pc_i) + 32'd4))
    else $error("pc did not advance by four");

  no_x0_write_a: assert property (@(posedge clk)
    commit_i.we |-> (commit_i.addr != 5'd0))
    else $error("commit shows a write to x0");

endmodule

bind rv_pipeline_top rv_pipeline_checker chk0 (
  .clk      (clk),
  .reset_i  (reset_i),
  .pc_i     (pc_o),
  .commit_i (commit_o)
);

// ==== tb/rv_pipeline_tb.sv ====
`timescale 1ns/1ps

module rv_pipeline_tb;

  localparam int PROG_LEN       = 200;
  localparam int CLK_PERIOD     = 20;
  localparam int RESET_CYCLES   = 4;
  // program, reset, pipeline drain and some margin
  localparam int TIMEOUT_CYCLES = PROG_LEN + RESET_CYCLES + 26;

  // funct3 per instruction slot, three bits each, slot 0 lowest
  localparam logic [29:0] R_FUNCT3 = {3'd7, 3'd6, 3'd5, 3'd5, 3'd4, 3'd3, 3'd2, 3'd1, 3'd0, 3'd0};
  localparam logic [26:0] I_FUNCT3 = {3'd5, 3'd5, 3'd1, 3'd7, 3'd6, 3'd4, 3'd3, 3'd2, 3'd0};
  // reference operation of each immediate slot
  localparam logic [35:0] I_OPER   = {4'd7, 4'd6, 4'd2, 4'd9, 4'd8, 4'd5, 4'd4, 4'd3, 4'd0};

  logic            clk;
  logic            reset_i;
  rv_pkg::word_t   inst_i;
  rv_pkg::word_t   pc_o;
  rv_pkg::commit_t commit_o;

  rv_pkg::word_t   prog [0:PROG_LEN-1];
  rv_pkg::word_t   model_regs [0:7];
  rv_pkg::commit_t expected_q [$];
  rv_pkg::commit_t head;
  integer          seed;
  int              commit_cnt;
  int              expected_cnt;

  rv_pipeline_top dut0 (
    .clk      (clk),
    .reset_i  (reset_i),
    .inst_i   (inst_i),
    .pc_o     (pc_o),
    .commit_o (commit_o)
  );

  initial clk = 1'b0;
  always #(CLK_PERIOD / 2) clk = ~clk;

  task automatic abort_run(input string msg);
    $display("%s", msg);
    $display("TESTBENCH FAILED");
    $fatal(1, "run stopped on first error");
  endtask

  task automatic show_mismatch(input string name, input rv_pkg::word_t got,
                               input rv_pkg::word_t exp);
    abort_run($sformatf("ERR time=%0t %s got=%08h expected=%08h", $time, name, got, exp));
  endtask

  // rv32i semantics, op order add sub sll slt sltu xor srl sra or and
  function automatic rv_pkg::word_t ref_alu(input logic [3:0] op, input rv_pkg::word_t a,
                                            input rv_pkg::word_t b);
    rv_pkg::word_t res;
    case (op)
      4'd0:    res = a + b;
      4'd1:    res = a - b;
      4'd2:    res = a << b[4:0];
      // differing signs decide on their own
      4'd3:    res = {31'b0, (a[31] != b[31]) ? a[31] : (a < b)};
      4'd4:    res = {31'b0, a < b};
      4'd5:    res = a ^ b;
      4'd6:    res = a >> b[4:0];
      // logical shift, then refill the vacated top bits with the sign
      4'd7:    res = (a >> b[4:0]) | ({32{a[31]}} & ~(32'hffff_ffff >> b[4:0]));
      4'd8:    res = a | b;
      default: res = a & b;
    endcase
    return res;
  endfunction

  // ==================================================
  // random program and in-order reference model
  // ==================================================
  // slots 0-9 register ops, 10-18 immediate ops, 19 lui, 20 auipc
  task automatic add_instruction(input int idx);
    int              kind;
    logic [2:0]      rd;
    logic [2:0]      rs1;
    logic [2:0]      rs2;
    logic [2:0]      f3;
    logic [6:0]      f7;
    logic [11:0]     imm12;
    logic [19:0]     imm20;
    rv_pkg::word_t   a;
    rv_pkg::word_t   b;
    rv_pkg::word_t   res;
    rv_pkg::commit_t entry;
    kind  = $unsigned($random(seed)) % 21;
    rd    = 3'($random(seed));
    rs1   = 3'($random(seed));
    rs2   = 3'($random(seed));
    imm12 = 12'($random(seed));
    imm20 = 20'($random(seed));
    a     = model_regs[rs1];
    b     = model_regs[rs2];
    if (kind < 10) begin
      f3 = 3'(R_FUNCT3 >> (3 * kind));
      f7 = ((kind == 1) || (kind == 7)) ? 7'h20 : 7'h00;
      prog[idx] = {f7, 2'b00, rs2, 2'b00, rs1, f3, 2'b00, rd, rv_pkg::OPC_OP};
      res = ref_alu(4'(kind), a, b);
    end else if (kind < 19) begin
      // shift immediates keep funct7 in the upper bits, srai sets bit 30
      if (kind >= 16) begin
        imm12[11:5] = (kind == 18) ? 7'h20 : 7'h00;
      end
      f3 = 3'(I_FUNCT3 >> (3 * (kind - 10)));
      prog[idx] = {imm12, 2'b00, rs1, f3, 2'b00, rd, rv_pkg::OPC_OP_IMM};
      res = ref_alu(4'(I_OPER >> (4 * (kind - 10))), a, {{20{imm12[11]}}, imm12});
    end else begin
      prog[idx] = {imm20, 2'b00, rd, (kind == 19) ? rv_pkg::OPC_LUI : rv_pkg::OPC_AUIPC};
      res = {imm20, 12'b0};
      if (kind == 20) begin
        res = res + 32'(4 * idx);
      end
    end
    if (rd != 3'd0) begin
      model_regs[rd] = res;
      entry = '{we: 1'b1, addr: {2'b00, rd}, data: res};
      expected_q.push_back(entry);
      expected_cnt++;
    end
  endtask

  // ==================================================
  // instruction memory and commit checks
  // ==================================================
  always @(negedge clk) begin
    if (pc_o < 32'(4 * PROG_LEN)) begin
      inst_i <= prog[pc_o[9:2]];
    end else begin
      inst_i <= rv_pkg::NOP_INST;
    end
  end

  // commit_o only moves on the rising edge
  always @(negedge clk) begin
    if (commit_o.we === 1'b1) begin
      commit_cnt++;
      if (expected_q.size() == 0) begin
        abort_run("commit seen after every expected write had retired");
      end else begin
        head = expected_q.pop_front();
        assert (commit_o.addr == head.addr)
          else show_mismatch("commit_o.addr", 32'(commit_o.addr), 32'(head.addr));
        assert (commit_o.data == head.data)
          else show_mismatch("commit_o.data", commit_o.data, head.data);
      end
    end
  end

  initial begin
    seed         = 32'hc4ad108f;
    commit_cnt   = 0;
    expected_cnt = 0;
    reset_i      = 1'b1;
    inst_i       = rv_pkg::NOP_INST;
    for (int r = 0; r < 8; r++) begin
      model_regs[r] = '0;
    end
    for (int i = 0; i < PROG_LEN; i++) begin
      add_instruction(i);
    end
    repeat (RESET_CYCLES) @(negedge clk);
    reset_i <= 1'b0;
    // last instruction retires three edges after its fetch
    while (pc_o != 32'(4 * (PROG_LEN + 4))) begin
      @(negedge clk);
    end
    @(negedge clk);
    if ((expected_q.size() == 0) && (commit_cnt == expected_cnt)) begin
      $display("TESTBENCH PASSED");
      $finish;
    end else begin
      abort_run($sformatf("saw %0d commits but the program has %0d register writes",
                          commit_cnt, expected_cnt));
    end
  end

  initial begin
    #(TIMEOUT_CYCLES * CLK_PERIOD);
    abort_run("timeout: the program did not finish retiring in time");
  end

endmodule

// ==== sim.f ====
src/rv_pkg.sv
src/fetch_stage.sv
src/reg_file.sv
src/decode_stage.sv
src/execute_stage.sv
src/rv_pipeline_top.sv
tb/rv_pipeline_checker.sv
tb/rv_pipeline_tb.sv

// ==== run.sh ====
#!/bin/sh
# build and run the rv_pipeline testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/1ps \
  -f sim.f --top-module rv_pipeline_tb -o rv_pipeline_sim

# the log decides the result, so a failing run must not stop the script here
./obj_dir/rv_pipeline_sim > sim.log 2>&1 || true
cat sim.log

if grep -q "TESTBENCH PASSED" sim.log; then
  exit 0
else
  exit 1
fi
